// ==== include/armCore_settings.svh ====
`ifndef ARMCORE_SETTINGS_SVH
`define ARMCORE_SETTINGS_SVH

// Datapath and memory word width in bits
`define ARM_XLEN 32

// Architectural registers R0 to R15, R15 being the PC
`define ARM_REG_COUNT 16

// First fetch address coming out of reset
`define ARM_RESET_PC 32'h0000_0000

`endif

// ==== logic/armCorePkg.sv ====
`include "armCore_settings.svh"

package armCorePkg;

  // One machine word
  typedef logic [`ARM_XLEN-1:0] wordT;

  // Register number, R15 is all ones
  typedef logic [$clog2(`ARM_REG_COUNT)-1:0] regNumT;

  // ==============================
  // Instruction word views
  // ==============================

  // Data-processing layout
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        imm;
    logic [3:0]  cmd;
    logic        s;
    regNumT      rn;
    regNumT      rd;
    // Rotate in [11:8] and imm8 in [7:0], or shift and Rm
    logic [11:0] operand2;
  } dpFieldsT;

  // Single word load and store layout
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    // Low selects the immediate offset form
    logic        immN;
    logic        pre;
    logic        up;
    logic        byteAcc;
    logic        wb;
    logic        load;
    regNumT      rn;
    regNumT      rd;
    logic [11:0] offset;
  } memFieldsT;

  // Branch layout
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    // Bit 25, set for B and BL
    logic        bTag;
    logic        link;
    logic [23:0] offset;
  } brFieldsT;

  typedef union packed {
    dpFieldsT  dpView;
    memFieldsT memView;
    brFieldsT  brView;
  } instrWordT;

  // ==============================
  // Control encodings
  // ==============================

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluPassB
  } aluOpT;

  // Immediate extension format
  typedef enum logic [1:0] {
    immRot,
    immOff12,
    immBranch
  } immSrcT;

  typedef enum logic [1:0] {
    fwdReg     = 2'b00,
    fwdResultW = 2'b01,
    fwdAluOutM = 2'b10
  } forwardSelT;

  // Per-instruction control, cleared to a no-op
  typedef struct packed {
    logic   regWrite;
    logic   memWrite;
    logic   memToReg;
    logic   aluSrcImm;
    logic   branch;
    aluOpT  aluOp;
    immSrcT immSrc;
  } decodeCtrlT;

  typedef struct packed {
    logic       stallF;
    logic       stallD;
    logic       flushD;
    logic       flushE;
    forwardSelT forwardA;
    forwardSelT forwardB;
  } hazardCtrlT;

  // Source registers in D and E, destinations in E, M and W
  typedef struct packed {
    regNumT ra1D;
    regNumT ra2D;
    regNumT ra1E;
    regNumT ra2E;
    regNumT waE;
    regNumT waM;
    regNumT waW;
  } regAddrT;

endpackage

// ==== logic/regFile.sv ====
`timescale 1ns/100ps
`include "armCore_settings.svh"

module regFile (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              writeEnable,
  input  logic [$clog2(`ARM_REG_COUNT)-1:0] ra1,
  input  logic [$clog2(`ARM_REG_COUNT)-1:0] ra2,
  input  logic [$clog2(`ARM_REG_COUNT)-1:0] wa3,
  input  logic [`ARM_XLEN-1:0]              wd3,
  input  logic [`ARM_XLEN-1:0]              pcPlus8,
  output logic [`ARM_XLEN-1:0]              rd1,
  output logic [`ARM_XLEN-1:0]              rd2
);

  // Index of the PC register
  localparam int PcIdx = `ARM_REG_COUNT - 1;

  logic [`ARM_XLEN-1:0] regs [`ARM_REG_COUNT];

  // Falling edge write, so a read in the same cycle sees the new value
  always_ff @(negedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `ARM_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[wa3] <= wd3;
    end
  end

  // R15 reads as the fetch address plus 8
  assign rd1 = (ra1 == PcIdx) ? pcPlus8 : regs[ra1];
  assign rd2 = (ra2 == PcIdx) ? pcPlus8 : regs[ra2];

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/100ps
`include "armCore_settings.svh"

module datapath (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`ARM_XLEN-1:0]   instr,
  input  logic [`ARM_XLEN-1:0]   readData,
  output logic [`ARM_XLEN-1:0]   pc,
  output armCorePkg::instrWordT  instrD,
  input  armCorePkg::decodeCtrlT ctrlE,
  input  armCorePkg::decodeCtrlT ctrlW,
  input  armCorePkg::immSrcT     immSrcD,
  input  armCorePkg::hazardCtrlT hazard,
  input  armCorePkg::regAddrT    regAddr,
  output logic                   branchTakenE,
  output logic [`ARM_XLEN-1:0]   aluOutM,
  output logic [`ARM_XLEN-1:0]   writeDataM
);
  import armCorePkg::*;

  wordT pcPlus4F;
  wordT pcNextF;
  wordT extImmD;
  wordT rd1D;
  wordT rd2D;
  // Doubled imm8 shifted right, the low half is the rotation
  logic [2*`ARM_XLEN-1:0] rotPairD;
  wordT rd1E;
  wordT rd2E;
  wordT extImmE;
  wordT srcAE;
  wordT srcBE;
  wordT writeDataE;
  wordT aluResultE;
  wordT aluOutW;
  wordT readDataW;
  wordT resultW;

  // Operand source for one ALU input
  function automatic wordT fwdMux(forwardSelT sel, wordT regVal, wordT resW, wordT aluM);
    unique case (sel)
      fwdResultW: return resW;
      fwdAluOutM: return aluM;
      default:    return regVal;
    endcase
  endfunction

  // ==============================
  // Fetch
  // ==============================
  assign pcPlus4F = pc + wordT'(4);
  // Taken branch target comes straight from the execute ALU
  assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= `ARM_RESET_PC;
    end else if (!hazard.stallF) begin
      pc <= pcNextF;
    end
  end

  // ==============================
  // Decode
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= '0;
    end else if (hazard.flushD) begin
      // Zero word decodes as a no-op
      instrD <= '0;
    end else if (!hazard.stallD) begin
      instrD <= instr;
    end
  end

  // While instrD decodes, pc already points 4 past it
  regFile u_regFile (
    .clk         (clk),
    .rstN        (rstN),
    .writeEnable (ctrlW.regWrite),
    .ra1         (regAddr.ra1D),
    .ra2         (regAddr.ra2D),
    .wa3         (regAddr.waW),
    .wd3         (resultW),
    .pcPlus8     (pcPlus4F),
    .rd1         (rd1D),
    .rd2         (rd2D)
  );

  // Rotate right by twice the 4-bit rotate field
  assign rotPairD = {2{wordT'(instrD.dpView.operand2[7:0])}} >>
                    {instrD.dpView.operand2[11:8], 1'b0};

  always_comb begin
    unique case (immSrcD)
      immRot:    extImmD = rotPairD[`ARM_XLEN-1:0];
      immOff12:  extImmD = wordT'(instrD.memView.offset);
      // Signed word offset turned into a byte offset
      immBranch: extImmD = {{6{instrD.brView.offset[23]}}, instrD.brView.offset, 2'b00};
      default:   extImmD = '0;
    endcase
  end

  // ==============================
  // Execute
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rd1E    <= '0;
      rd2E    <= '0;
      extImmE <= '0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
    end
  end

  // Forwarding, the B path doubles as store data
  assign srcAE      = fwdMux(hazard.forwardA, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(hazard.forwardB, rd2E, resultW, aluOutM);
  assign srcBE      = ctrlE.aluSrcImm ? extImmE : writeDataE;

  always_comb begin
    unique case (ctrlE.aluOp)
      aluAdd:   aluResultE = srcAE + srcBE;
      aluSub:   aluResultE = srcAE - srcBE;
      aluAnd:   aluResultE = srcAE & srcBE;
      aluOrr:   aluResultE = srcAE | srcBE;
      aluPassB: aluResultE = srcBE;
      default:  aluResultE = '0;
    endcase
  end

  // Only unconditional B is decoded, so a branch in E is always taken
  assign branchTakenE = ctrlE.branch;

  // ==============================
  // Memory and writeback
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluOutM    <= '0;
      writeDataM <= '0;
      aluOutW    <= '0;
      readDataW  <= '0;
    end else begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
      aluOutW    <= aluOutM;
      readDataW  <= readData;
    end
  end

  assign resultW = ctrlW.memToReg ? readDataW : aluOutW;

endmodule

// ==== logic/controller.sv ====
`timescale 1ns/100ps

module controller (
  input  logic                   clk,
  input  logic                   rstN,
  input  armCorePkg::instrWordT  instrD,
  input  logic                   flushE,
  output armCorePkg::decodeCtrlT ctrlE,
  output armCorePkg::decodeCtrlT ctrlM,
  output armCorePkg::decodeCtrlT ctrlW,
  output armCorePkg::immSrcT     immSrcD,
  output armCorePkg::regAddrT    regAddr
);
  import armCorePkg::*;

  // Condition and op field encodings
  localparam logic [3:0] CondAlways = 4'b1110;
  localparam logic [1:0] OpDataProc = 2'b00;
  localparam logic [1:0] OpMemory   = 2'b01;
  localparam logic [1:0] OpBranch   = 2'b10;
  // Data-processing cmd encodings
  localparam logic [3:0] CmdAnd = 4'b0000;
  localparam logic [3:0] CmdSub = 4'b0010;
  localparam logic [3:0] CmdAdd = 4'b0100;
  localparam logic [3:0] CmdOrr = 4'b1100;
  localparam logic [3:0] CmdMov = 4'b1101;
  // R15
  localparam regNumT PcReg = '1;

  decodeCtrlT ctrlD;
  regNumT     ra1D;
  regNumT     ra2D;
  regNumT     waD;
  regNumT     ra1E;
  regNumT     ra2E;
  regNumT     waE;
  regNumT     waM;
  regNumT     waW;

  // ==============================
  // Decode
  // ==============================
  always_comb begin
    ctrlD = '0;
    ra1D  = instrD.dpView.rn;
    ra2D  = instrD.dpView.operand2[3:0];
    waD   = instrD.dpView.rd;
    // Anything else than AL stays a no-op
    if (instrD.dpView.cond == CondAlways) begin
      unique case (instrD.dpView.op)
        OpDataProc: begin
          // Register operand only without shift, no write to R15
          if (instrD.dpView.rd != PcReg &&
              (instrD.dpView.imm || instrD.dpView.operand2[11:4] == '0)) begin
            ctrlD.aluSrcImm = instrD.dpView.imm;
            ctrlD.regWrite  = 1'b1;
            unique case (instrD.dpView.cmd)
              CmdAdd:  ctrlD.aluOp = aluAdd;
              CmdSub:  ctrlD.aluOp = aluSub;
              CmdAnd:  ctrlD.aluOp = aluAnd;
              CmdOrr:  ctrlD.aluOp = aluOrr;
              CmdMov:  ctrlD.aluOp = aluPassB;
              default: ctrlD = '0;
            endcase
          end
        end
        OpMemory: begin
          // Pre-indexed word access with positive immediate, no writeback
          if (!instrD.memView.immN && instrD.memView.pre && instrD.memView.up &&
              !instrD.memView.byteAcc && !instrD.memView.wb &&
              !(instrD.memView.load && instrD.memView.rd == PcReg)) begin
            ctrlD.regWrite  = instrD.memView.load;
            ctrlD.memToReg  = instrD.memView.load;
            ctrlD.memWrite  = !instrD.memView.load;
            ctrlD.aluSrcImm = 1'b1;
            ctrlD.aluOp     = aluAdd;
            ctrlD.immSrc    = immOff12;
          end
          ra1D = instrD.memView.rn;
          // Store data is read through the second port
          ra2D = instrD.memView.rd;
          waD  = instrD.memView.rd;
        end
        OpBranch: begin
          // Plain B, target is PC plus 8 plus the offset
          if (instrD.brView.bTag && !instrD.brView.link) begin
            ctrlD.branch    = 1'b1;
            ctrlD.aluSrcImm = 1'b1;
            ctrlD.aluOp     = aluAdd;
            ctrlD.immSrc    = immBranch;
          end
          ra1D = PcReg;
        end
        default: ctrlD = '0;
      endcase
    end
  end

  assign immSrcD = ctrlD.immSrc;

  // ==============================
  // Control pipeline
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE <= '0;
      ctrlM <= '0;
      ctrlW <= '0;
      ra1E  <= '0;
      ra2E  <= '0;
      waE   <= '0;
      waM   <= '0;
      waW   <= '0;
    end else begin
      // Flush turns the E slot into a bubble
      ctrlE <= flushE ? '0 : ctrlD;
      ctrlM <= ctrlE;
      ctrlW <= ctrlM;
      ra1E  <= ra1D;
      ra2E  <= ra2D;
      waE   <= waD;
      waM   <= waE;
      waW   <= waM;
    end
  end

  assign regAddr = '{ra1D: ra1D, ra2D: ra2D, ra1E: ra1E, ra2E: ra2E,
                     waE: waE, waM: waM, waW: waW};

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
  input  armCorePkg::regAddrT    regAddr,
  input  logic                   memToRegE,
  input  logic                   regWriteM,
  input  logic                   regWriteW,
  input  logic                   branchTakenE,
  output armCorePkg::hazardCtrlT hazard
);
  import armCorePkg::*;

  logic ldrStall;

  // Youngest producer wins, so M is checked before W
  function automatic forwardSelT pickForward(
    regNumT srcReg,
    regNumT waM,
    logic   wrM,
    regNumT waW,
    logic   wrW
  );
    if (wrM && srcReg == waM) begin
      return fwdAluOutM;
    end else if (wrW && srcReg == waW) begin
      return fwdResultW;
    end
    return fwdReg;
  endfunction

  // ==============================
  // Load-use detection
  // ==============================
  // Load in E, its destination read by the instruction in D
  assign ldrStall = memToRegE &&
                    (regAddr.ra1D == regAddr.waE || regAddr.ra2D == regAddr.waE);

  always_comb begin
    hazard.forwardA = pickForward(regAddr.ra1E, regAddr.waM, regWriteM,
                                  regAddr.waW, regWriteW);
    hazard.forwardB = pickForward(regAddr.ra2E, regAddr.waM, regWriteM,
                                  regAddr.waW, regWriteW);
    // Hold F and D one cycle, bubble goes into E
    hazard.stallF = ldrStall;
    hazard.stallD = ldrStall;
    // Taken branch kills the two younger instructions
    hazard.flushD = branchTakenE;
    hazard.flushE = ldrStall || branchTakenE;
  end

endmodule

// ==== logic/armCore.sv ====
`timescale 1ns/100ps
`include "armCore_settings.svh"

module armCore (
  input  logic                 clk,
  input  logic                 rstN,
  output logic [`ARM_XLEN-1:0] pc,
  input  logic [`ARM_XLEN-1:0] instr,
  output logic [`ARM_XLEN-1:0] dataAdr,
  output logic [`ARM_XLEN-1:0] writeData,
  output logic                 memWrite,
  input  logic [`ARM_XLEN-1:0] readData
);
  import armCorePkg::*;

  instrWordT  instrD;
  decodeCtrlT ctrlE;
  decodeCtrlT ctrlM;
  decodeCtrlT ctrlW;
  immSrcT     immSrcD;
  hazardCtrlT hazard;
  regAddrT    regAddr;
  logic       branchTakenE;
  wordT       aluOutM;

  controller u_controller (
    .clk     (clk),
    .rstN    (rstN),
    .instrD  (instrD),
    .flushE  (hazard.flushE),
    .ctrlE   (ctrlE),
    .ctrlM   (ctrlM),
    .ctrlW   (ctrlW),
    .immSrcD (immSrcD),
    .regAddr (regAddr)
  );

  hazardUnit u_hazardUnit (
    .regAddr      (regAddr),
    .memToRegE    (ctrlE.memToReg),
    .regWriteM    (ctrlM.regWrite),
    .regWriteW    (ctrlW.regWrite),
    .branchTakenE (branchTakenE),
    .hazard       (hazard)
  );

  datapath u_datapath (
    .clk          (clk),
    .rstN         (rstN),
    .instr        (instr),
    .readData     (readData),
    .pc           (pc),
    .instrD       (instrD),
    .ctrlE        (ctrlE),
    .ctrlW        (ctrlW),
    .immSrcD      (immSrcD),
    .hazard       (hazard),
    .regAddr      (regAddr),
    .branchTakenE (branchTakenE),
    .aluOutM      (aluOutM),
    .writeDataM   (writeData)
  );

  // Memory stage drives the data port
  assign dataAdr  = aluOutM;
  assign memWrite = ctrlM.memWrite;

endmodule

// ==== testbench/armCore_sva.sv ====
`timescale 1ns/100ps
`include "armCore_settings.svh"

module armCore_sva (
  input logic                 clk,
  input logic                 rstN,
  input logic [`ARM_XLEN-1:0] pc,
  input logic [`ARM_XLEN-1:0] dataAdr,
  input logic                 memWrite,
  input logic                 stallF
);

  // ==============================
  // Reset state
  // ==============================
  // Fetch stays parked at the reset vector
  resetPcA: assert property (@(posedge clk) !rstN |-> pc == `ARM_RESET_PC)
    else $error("pc moved away from the reset vector during reset");

  // Bubbles only, so no store leaves the core
  resetStoreA: assert property (@(posedge clk) !rstN |-> !memWrite)
    else $error("memWrite raised during reset");

  // ==============================
  // Pipeline rules
  // ==============================
  // Load-use stall holds the fetch address
  stallPcA: assert property (@(posedge clk) disable iff (!rstN) stallF |=> $stable(pc))
    else $error("pc changed across a fetch stall");

  // Word accesses only
  alignA: assert property (@(posedge clk) disable iff (!rstN)
                           memWrite |-> dataAdr[1:0] == 2'b00)
    else $error("store to an unaligned address");

endmodule

bind armCore armCore_sva u_sva (
  .clk      (clk),
  .rstN     (rstN),
  .pc       (pc),
  .dataAdr  (dataAdr),
  .memWrite (memWrite),
  .stallF   (hazard.stallF)
);

// ==== testbench/tb_armCore.sv ====
`timescale 1ns/100ps
`include "armCore_settings.svh"

module tb_armCore;

  localparam int ProgWords    = 64;
  localparam int DataWords    = 256;
  localparam int StoreTimeout = 400;
  // ARM data-processing cmd field
  localparam logic [3:0] CmdAnd = 4'b0000;
  localparam logic [3:0] CmdSub = 4'b0010;
  localparam logic [3:0] CmdAdd = 4'b0100;
  localparam logic [3:0] CmdOrr = 4'b1100;
  localparam logic [3:0] CmdMov = 4'b1101;

  logic                 clk;
  logic                 rstN;
  logic [`ARM_XLEN-1:0] pc;
  logic [`ARM_XLEN-1:0] instr;
  logic [`ARM_XLEN-1:0] dataAdr;
  logic [`ARM_XLEN-1:0] writeData;
  logic                 memWrite;
  logic [`ARM_XLEN-1:0] readData;

  logic [`ARM_XLEN-1:0] progMem [ProgWords];
  logic [`ARM_XLEN-1:0] dataMem [DataWords];
  logic [7:0]           immVal [6];
  // Expected stores in program order
  logic [`ARM_XLEN-1:0] expAddrQ [$];
  logic [`ARM_XLEN-1:0] expDataQ [$];

  integer seed;
  int     obsCount    = 0;
  int     checkCount  = 0;
  int     valueErrors = 0;
  int     otherErrors = 0;

  armCore u_dut (
    .clk       (clk),
    .rstN      (rstN),
    .pc        (pc),
    .instr     (instr),
    .dataAdr   (dataAdr),
    .writeData (writeData),
    .memWrite  (memWrite),
    .readData  (readData)
  );

  // ==============================
  // Instruction encoders
  // ==============================
  function automatic logic [31:0] dpImmInstr(logic [3:0] cmd, logic [3:0] rn, logic [3:0] rd,
                                             logic [3:0] rot, logic [7:0] imm8);
    return {4'hE, 2'b00, 1'b1, cmd, 1'b0, rn, rd, rot, imm8};
  endfunction

  function automatic logic [31:0] dpRegInstr(logic [3:0] cmd, logic [3:0] rn, logic [3:0] rd,
                                             logic [3:0] rm);
    return {4'hE, 2'b00, 1'b0, cmd, 1'b0, rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed, up, word, no writeback
  function automatic logic [31:0] ldrStrInstr(logic load, logic [3:0] rn, logic [3:0] rd,
                                              logic [11:0] off12);
    return {4'hE, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off12};
  endfunction

  function automatic logic [31:0] branchInstr(logic [23:0] off24);
    return {4'hE, 2'b10, 1'b1, 1'b0, off24};
  endfunction

  // Initial data memory contents, mixed over every address bit
  function automatic logic [31:0] fillWord(logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
  endfunction

  function automatic logic [31:0] rotateRight(logic [31:0] val, logic [4:0] amt);
    if (amt == 5'd0) begin
      return val;
    end
    return (val >> amt) | (val << (6'd32 - {1'b0, amt}));
  endfunction

  // ==============================
  // Reference model
  // ==============================
  // Runs the program one instruction at a time, no pipeline
  function automatic void refRun();
    logic [`ARM_XLEN-1:0] regs [`ARM_REG_COUNT];
    logic [`ARM_XLEN-1:0] mem [DataWords];
    logic [`ARM_XLEN-1:0] pcRef;
    logic [`ARM_XLEN-1:0] iw;
    logic [`ARM_XLEN-1:0] opB;
    logic [`ARM_XLEN-1:0] adr;
    logic [`ARM_XLEN-1:0] target;
    logic                 done;
    int                   steps;
    for (int i = 0; i < `ARM_REG_COUNT; i++) begin
      regs[i] = '0;
    end
    for (int j = 0; j < DataWords; j++) begin
      mem[j] = fillWord(j * 4);
    end
    pcRef = `ARM_RESET_PC;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 200) begin
      iw = progMem[pcRef[7:2]];
      // R15 reads two instructions ahead
      regs[15] = pcRef + 32'd8;
      steps++;
      if (iw[27:26] == 2'b10) begin
        target = pcRef + 32'd8 + {{6{iw[23]}}, iw[23:0], 2'b00};
        // Branch to itself ends the program
        done  = (target == pcRef);
        pcRef = target;
      end else if (iw[27:26] == 2'b01) begin
        adr = regs[iw[19:16]] + {20'd0, iw[11:0]};
        if (iw[20]) begin
          regs[iw[15:12]] = mem[adr[9:2]];
        end else begin
          mem[adr[9:2]] = regs[iw[15:12]];
          expAddrQ.push_back(adr);
          expDataQ.push_back(regs[iw[15:12]]);
        end
        pcRef = pcRef + 32'd4;
      end else begin
        opB = iw[25] ? rotateRight({24'd0, iw[7:0]}, {iw[11:8], 1'b0}) : regs[iw[3:0]];
        case (iw[24:21])
          CmdAdd:  regs[iw[15:12]] = regs[iw[19:16]] + opB;
          CmdSub:  regs[iw[15:12]] = regs[iw[19:16]] - opB;
          CmdAnd:  regs[iw[15:12]] = regs[iw[19:16]] & opB;
          CmdOrr:  regs[iw[15:12]] = regs[iw[19:16]] | opB;
          CmdMov:  regs[iw[15:12]] = opB;
          default: ;
        endcase
        pcRef = pcRef + 32'd4;
      end
    end
  endfunction

  task automatic loadProgram();
    for (int i = 0; i < ProgWords; i++) begin
      progMem[i] = '0;
    end
    // Base pointer 0x100, imm8 1 rotated right by 24
    progMem[0]  = dpImmInstr(CmdMov, 4'd0, 4'd13, 4'd12, 8'h01);
    // Immediate ops, each one reads the previous result
    progMem[1]  = dpImmInstr(CmdMov, 4'd0, 4'd1, 4'd0, immVal[0]);
    progMem[2]  = dpImmInstr(CmdAdd, 4'd1, 4'd2, 4'd0, immVal[1]);
    progMem[3]  = dpImmInstr(CmdSub, 4'd2, 4'd3, 4'd0, immVal[2]);
    progMem[4]  = dpImmInstr(CmdAnd, 4'd3, 4'd4, 4'd0, immVal[3]);
    progMem[5]  = dpImmInstr(CmdOrr, 4'd4, 4'd5, 4'd15, immVal[4]);
    progMem[6]  = dpImmInstr(CmdMov, 4'd0, 4'd6, 4'd4, immVal[5]);
    for (int k = 0; k < 6; k++) begin
      progMem[7+k] = ldrStrInstr(1'b0, 4'd13, 4'(k + 1), 12'(k * 4));
    end
    // Register operands forwarded at distance 1 and 2
    progMem[13] = dpRegInstr(CmdAdd, 4'd1, 4'd7, 4'd2);
    progMem[14] = dpRegInstr(CmdSub, 4'd7, 4'd8, 4'd1);
    progMem[15] = dpRegInstr(CmdOrr, 4'd6, 4'd10, 4'd7);
    progMem[16] = ldrStrInstr(1'b0, 4'd13, 4'd10, 12'd28);
    progMem[17] = ldrStrInstr(1'b0, 4'd13, 4'd8, 12'd24);
    // Load then immediate use
    progMem[18] = ldrStrInstr(1'b1, 4'd13, 4'd9, 12'h200);
    progMem[19] = dpRegInstr(CmdAdd, 4'd9, 4'd11, 4'd1);
    progMem[20] = ldrStrInstr(1'b0, 4'd13, 4'd11, 12'd32);
    // Skips the two stores behind it
    progMem[21] = branchInstr(24'd1);
    progMem[22] = ldrStrInstr(1'b0, 4'd13, 4'd1, 12'd36);
    progMem[23] = ldrStrInstr(1'b0, 4'd13, 4'd2, 12'd40);
    progMem[24] = ldrStrInstr(1'b0, 4'd13, 4'd7, 12'd44);
    progMem[25] = branchInstr(24'hFF_FFFE);
  endtask

  // ==============================
  // Checks
  // ==============================
  task automatic checkWord(string name, logic [`ARM_XLEN-1:0] got, logic [`ARM_XLEN-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      valueErrors++;
      $display("Fail at %0.1f ns: %s is %h, expected %h", $realtime, name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
      valueErrors++;
      $display("Fail at %0.1f ns: %s is %b, expected %b", $realtime, name, got, exp);
    end
  endtask

  // Store comparison, sampled mid-cycle
  always @(negedge clk) begin
    if (!rstN) begin
      checkBit("memWrite", memWrite, 1'b0);
    end else if (memWrite === 1'b1) begin
      if (obsCount < expAddrQ.size()) begin
        checkWord("dataAdr", dataAdr, expAddrQ[obsCount]);
        checkWord("writeData", writeData, expDataQ[obsCount]);
      end else begin
        otherErrors++;
        $display("Extra store to address %h at %0.1f ns after the program ended",
                 dataAdr, $realtime);
      end
      obsCount++;
    end
  end

  // ==============================
  // Clock and memory models
  // ==============================
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    instr = '0;
    forever begin
      @(posedge clk);
      #1;
      instr = progMem[pc[7:2]];
    end
  end

  assign readData = dataMem[dataAdr[9:2]];

  initial begin
    for (int i = 0; i < DataWords; i++) begin
      dataMem[i] = fillWord(i * 4);
    end
    forever begin
      @(negedge clk);
      if (rstN && memWrite) begin
        dataMem[dataAdr[9:2]] = writeData;
      end
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    logic [`ARM_XLEN-1:0] rnd;
    int                   waitCycles;
    int                   missing;
    rstN    = 1'b0;
    missing = 0;
    seed    = 32'h700a3346;
    for (int i = 0; i < 6; i++) begin
      rnd       = $random(seed);
      immVal[i] = rnd[7:0];
    end
    loadProgram();
    refRun();
    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;
    waitCycles = 0;
    while (obsCount < expAddrQ.size() && waitCycles < StoreTimeout) begin
      @(posedge clk);
      waitCycles++;
    end
    if (obsCount < expAddrQ.size()) begin
      missing = expAddrQ.size() - obsCount;
      $display("Store %0d to address %h never happened within %0d cycles",
               obsCount + 1, expAddrQ[obsCount], StoreTimeout);
    end
    $display("Checks %0d, value errors %0d, other errors %0d, missing stores %0d",
             checkCount, valueErrors, otherErrors, missing);
    if (valueErrors == 0 && otherErrors == 0 && missing == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
logic/armCorePkg.sv
logic/regFile.sv
logic/datapath.sv
logic/controller.sv
logic/hazardUnit.sv
logic/armCore.sv
testbench/armCore_sva.sv
testbench/tb_armCore.sv

// ==== Makefile ====
TOP := tb_armCore

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
